// File: source/mem_pkg.sv
`default_nettype none

package mem_pkg;

    //////////////////////////////////////////////////////////////////////
    // Widths and region map
    //////////////////////////////////////////////////////////////////////

    localparam int addr_w = 32;
    localparam int data_w = 32;
    localparam int strb_w = 4;

    // Single word console port, checked before the peripheral range
    localparam logic [addr_w-1:0] exit_fifo_addr = 32'h0001_0150;
    localparam logic [addr_w-1:0] peri_base_addr = 32'h1000_0000;

    //////////////////////////////////////////////////////////////////////
    // Encodings
    //////////////////////////////////////////////////////////////////////

    // Data operation from the memory stage
    typedef enum logic [1:0] {
        op_idle  = 2'b00,
        op_read  = 2'b01,
        op_write = 2'b10,
        op_flush = 2'b11
    } mem_op_e;

    typedef enum logic [1:0] {
        reg_cache   = 2'b00,
        reg_console = 2'b01,
        reg_peri    = 2'b10
    } region_e;

    // Peripheral transaction sequencer
    typedef enum logic [1:0] {
        st_idle = 2'b00,
        st_req  = 2'b01,
        st_wait = 2'b10,
        st_done = 2'b11
    } peri_state_e;

    //////////////////////////////////////////////////////////////////////
    // Request bundles
    //////////////////////////////////////////////////////////////////////

    // Processor and cache side access, 70 bits
    typedef struct packed {
        mem_op_e             op;
        logic [addr_w-1:0]   addr;
        logic [data_w-1:0]   wdata;
        logic [strb_w-1:0]   strb;
    } mem_req_t;

    // Peripheral channel request, 69 bits
    typedef struct packed {
        logic                write;
        logic [addr_w-1:0]   addr;
        logic [data_w-1:0]   wdata;
        logic [strb_w-1:0]   strb;
    } peri_req_t;

endpackage

`default_nettype wire

// File: source/access_decode.sv
`default_nettype none

module access_decode
(
    input  wire logic                          CLK,
    input  wire logic                          rst,
    input  wire logic                          run_en,
    input  wire mem_pkg::mem_req_t             proc_req,
    input  wire logic                          cache_ready,
    input  wire logic [mem_pkg::data_w-1:0]    cache_rdata,
    input  wire logic                          peri_done,
    input  wire logic [mem_pkg::data_w-1:0]    peri_rdata_q,
    output mem_pkg::region_e                   region,
    output mem_pkg::mem_req_t                  cache_req,
    output logic                               proc_ready,
    output logic [mem_pkg::data_w-1:0]         proc_rdata,
    output logic                               console_valid,
    output logic [mem_pkg::data_w-1:0]         console_data
);

    logic console_accept;

    //////////////////////////////////////////////////////////////////////
    // Address decode
    //////////////////////////////////////////////////////////////////////

    // Console match wins over the peripheral range
    always_comb
    begin
        if (proc_req.addr == mem_pkg::exit_fifo_addr)
        begin
            region = mem_pkg::reg_console;
        end
        else if (proc_req.addr >= mem_pkg::peri_base_addr)
        begin
            region = mem_pkg::reg_peri;
        end
        else
        begin
            region = mem_pkg::reg_cache;
        end
    end

    // Cache sees the access only in its own region
    always_comb
    begin
        cache_req = proc_req;
        if (region != mem_pkg::reg_cache)
        begin
            cache_req.op = mem_pkg::op_idle;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Return path to the processor
    //////////////////////////////////////////////////////////////////////

    always_comb
    begin
        if (region == mem_pkg::reg_peri)
        begin
            proc_ready = peri_done;
            proc_rdata = peri_rdata_q;
        end
        else
        begin
            // Console accesses also complete on cache ready
            proc_ready = cache_ready;
            proc_rdata = cache_rdata;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Console write register
    //////////////////////////////////////////////////////////////////////

    assign console_accept = (region == mem_pkg::reg_console) &&
                            (proc_req.op == mem_pkg::op_write) &&
                            run_en && cache_ready;

    always_ff @(posedge CLK)
    begin
        if (rst)
        begin
            console_valid <= 1'b0;
        end
        else
        begin
            console_valid <= console_accept;
        end
    end

    always_ff @(posedge CLK)
    begin
        if (console_accept)
        begin
            console_data <= proc_req.wdata;
        end
    end

endmodule

`default_nettype wire

// File: source/peri_sequencer.sv
`default_nettype none

module peri_sequencer
(
    input  wire logic                          CLK,
    input  wire logic                          rst,
    input  wire logic                          start,
    input  wire mem_pkg::mem_req_t             proc_req,
    output mem_pkg::peri_req_t                 peri_req,
    output logic                               peri_req_valid,
    input  wire logic                          peri_req_ready,
    input  wire logic                          peri_resp_valid,
    input  wire logic [mem_pkg::data_w-1:0]    peri_rdata,
    output logic                               peri_done,
    output logic [mem_pkg::data_w-1:0]         peri_rdata_q
);

    mem_pkg::peri_state_e state;
    mem_pkg::peri_state_e state_next;

    //////////////////////////////////////////////////////////////////////
    // State machine
    //////////////////////////////////////////////////////////////////////

    always_comb
    begin
        state_next = state;
        case (state)
            mem_pkg::st_idle:
            begin
                if (start)
                begin
                    state_next = mem_pkg::st_req;
                end
            end
            mem_pkg::st_req:
            begin
                // Stays here as long as the peripheral pushes back
                if (peri_req_ready)
                begin
                    state_next = mem_pkg::st_wait;
                end
            end
            mem_pkg::st_wait:
            begin
                if (peri_resp_valid)
                begin
                    state_next = mem_pkg::st_done;
                end
            end
            mem_pkg::st_done:
            begin
                // Processor consumes the access on this edge
                state_next = mem_pkg::st_idle;
            end
            default:
            begin
                state_next = mem_pkg::st_idle;
            end
        endcase
    end

    always_ff @(posedge CLK)
    begin
        if (rst)
        begin
            state <= mem_pkg::st_idle;
        end
        else
        begin
            state <= state_next;
        end
    end

    assign peri_req_valid = (state == mem_pkg::st_req);
    assign peri_done      = (state == mem_pkg::st_done);

    //////////////////////////////////////////////////////////////////////
    // Request and response payload
    //////////////////////////////////////////////////////////////////////

    // Latched once so the channel stays stable while valid is high
    always_ff @(posedge CLK)
    begin
        if ((state == mem_pkg::st_idle) && start)
        begin
            // Read and flush both go out as reads
            peri_req.write <= (proc_req.op == mem_pkg::op_write);
            peri_req.addr  <= proc_req.addr;
            peri_req.wdata <= proc_req.wdata;
            peri_req.strb  <= proc_req.strb;
        end
    end

    // On a write the response only marks completion
    always_ff @(posedge CLK)
    begin
        if ((state == mem_pkg::st_wait) && peri_resp_valid)
        begin
            peri_rdata_q <= peri_rdata;
        end
    end

endmodule

`default_nettype wire

// File: source/data_port_router.sv
`default_nettype none

module data_port_router
(
    input  wire logic                          CLK,
    input  wire logic                          rst,
    input  wire logic                          run_en,

    // Processor memory stage
    input  wire mem_pkg::mem_req_t             proc_req,
    output logic                               proc_ready,
    output logic [mem_pkg::data_w-1:0]         proc_rdata,

    // Data cache port
    output mem_pkg::mem_req_t                  cache_req,
    input  wire logic                          cache_ready,
    input  wire logic [mem_pkg::data_w-1:0]    cache_rdata,

    // Peripheral channel
    output mem_pkg::peri_req_t                 peri_req,
    output logic                               peri_req_valid,
    input  wire logic                          peri_req_ready,
    input  wire logic                          peri_resp_valid,
    input  wire logic [mem_pkg::data_w-1:0]    peri_rdata,

    // Console output
    output logic                               console_valid,
    output logic [mem_pkg::data_w-1:0]         console_data
);

    mem_pkg::region_e                  region;
    logic                              peri_start;
    logic                              peri_done;
    logic [mem_pkg::data_w-1:0]        peri_rdata_q;

    // Range is decided once in the decoder
    assign peri_start = (region == mem_pkg::reg_peri) &&
                        (proc_req.op != mem_pkg::op_idle) &&
                        run_en && cache_ready;

    access_decode u_decode
    (
        .CLK           (CLK),
        .rst           (rst),
        .run_en        (run_en),
        .proc_req      (proc_req),
        .cache_ready   (cache_ready),
        .cache_rdata   (cache_rdata),
        .peri_done     (peri_done),
        .peri_rdata_q  (peri_rdata_q),
        .region        (region),
        .cache_req     (cache_req),
        .proc_ready    (proc_ready),
        .proc_rdata    (proc_rdata),
        .console_valid (console_valid),
        .console_data  (console_data)
    );

    peri_sequencer u_peri
    (
        .CLK             (CLK),
        .rst             (rst),
        .start           (peri_start),
        .proc_req        (proc_req),
        .peri_req        (peri_req),
        .peri_req_valid  (peri_req_valid),
        .peri_req_ready  (peri_req_ready),
        .peri_resp_valid (peri_resp_valid),
        .peri_rdata      (peri_rdata),
        .peri_done       (peri_done),
        .peri_rdata_q    (peri_rdata_q)
    );

endmodule

`default_nettype wire

// File: tests/data_port_router_sva.sv
`default_nettype none

module data_port_router_sva
(
    input wire logic                  CLK,
    input wire logic                  rst,
    input wire logic                  run_en,
    input wire mem_pkg::mem_req_t     proc_req,
    input wire mem_pkg::region_e      region,
    input wire logic                  proc_ready,
    input wire mem_pkg::peri_req_t    peri_req,
    input wire logic                  peri_req_valid,
    input wire logic                  peri_req_ready,
    input wire logic                  peri_resp_valid,
    input wire logic                  peri_done,
    input wire logic                  console_valid
);

    logic write_taken;

    // Console write consumed by the processor handshake
    assign write_taken = (proc_req.addr == mem_pkg::exit_fifo_addr) &&
                         (proc_req.op == mem_pkg::op_write) &&
                         run_en && proc_ready;

    // Request held stable until the peripheral takes it
    assert property (@(posedge CLK) disable iff (rst)
        peri_req_valid && !peri_req_ready |=> peri_req_valid && $stable(peri_req))
    else $error("peri_req_valid dropped or peri_req changed before peri_req_ready");

    assert property (@(posedge CLK) disable iff (rst)
        console_valid && !write_taken |=> !console_valid)
    else $error("console_valid stayed high without a new accepted write");

    // Peripheral accesses complete only from st_done, right after the response
    assert property (@(posedge CLK) disable iff (rst)
        (region == mem_pkg::reg_peri) && proc_ready |-> peri_done && $past(peri_resp_valid))
    else $error("proc_ready high in the peripheral region outside st_done");

endmodule

bind data_port_router data_port_router_sva u_sva
(
    .CLK             (CLK),
    .rst             (rst),
    .run_en          (run_en),
    .proc_req        (proc_req),
    .region          (region),
    .proc_ready      (proc_ready),
    .peri_req        (peri_req),
    .peri_req_valid  (peri_req_valid),
    .peri_req_ready  (peri_req_ready),
    .peri_resp_valid (peri_resp_valid),
    .peri_done       (peri_done),
    .console_valid   (console_valid)
);

`default_nettype wire

// File: tests/tb_data_port_router.sv
`default_nettype none

module tb_data_port_router;

    localparam int max_cases       = 32;
    localparam int fields          = 6;
    localparam int period          = 4;
    localparam int reset_cycles    = 10;
    localparam int cycles_per_case = 40;
    localparam int hold_cycles     = 8;

    logic                             CLK;
    logic                             rst;
    logic                             run_en;
    mem_pkg::mem_req_t                proc_req;
    logic                             proc_ready;
    logic [mem_pkg::data_w-1:0]       proc_rdata;
    mem_pkg::mem_req_t                cache_req;
    logic                             cache_ready;
    logic [mem_pkg::data_w-1:0]       cache_rdata;
    mem_pkg::peri_req_t               peri_req;
    logic                             peri_req_valid;
    logic                             peri_req_ready;
    logic                             peri_resp_valid;
    logic [mem_pkg::data_w-1:0]       peri_rdata;
    logic                             console_valid;
    logic [mem_pkg::data_w-1:0]       console_data;

    logic [31:0]  case_mem [0:max_cases*fields-1];
    logic [31:0]  peri_mem [logic [31:0]];
    int           n_cases = 0;
    int           errors = 0;
    int           checks = 0;
    int           peri_accepts = 0;
    bit           loaded;

    // Last request taken by the peripheral model
    mem_pkg::peri_req_t               peri_seen;

    data_port_router DUT
    (
        .CLK             (CLK),
        .rst             (rst),
        .run_en          (run_en),
        .proc_req        (proc_req),
        .proc_ready      (proc_ready),
        .proc_rdata      (proc_rdata),
        .cache_req       (cache_req),
        .cache_ready     (cache_ready),
        .cache_rdata     (cache_rdata),
        .peri_req        (peri_req),
        .peri_req_valid  (peri_req_valid),
        .peri_req_ready  (peri_req_ready),
        .peri_resp_valid (peri_resp_valid),
        .peri_rdata      (peri_rdata),
        .console_valid   (console_valid),
        .console_data    (console_data)
    );

    initial
    begin
        CLK = 1'b0;
    end

    always #(period/2) CLK = ~CLK;

    //////////////////////////////////////////////////////////////////////
    // Cache and peripheral models
    //////////////////////////////////////////////////////////////////////

    // Read data is the inverted address
    assign cache_rdata = ~cache_req.addr;

    initial
    begin : cache_model
        cache_ready = 1'b0;
        forever
        begin
            @(negedge CLK);
            // Ready about 70% of cycles
            cache_ready = ($urandom % 10) < 7;
        end
    end

    initial
    begin : peri_model
        int                 delay;
        mem_pkg::peri_req_t req;
        peri_req_ready  = 1'b0;
        peri_resp_valid = 1'b0;
        peri_rdata      = '0;
        forever
        begin
            @(negedge CLK);
            if (peri_req_valid)
            begin
                delay = $urandom % 4;
                repeat (delay) @(negedge CLK);
                req = peri_req;
                peri_seen = req;
                peri_req_ready = 1'b1;
                peri_accepts++;
                if (req.write)
                begin
                    peri_mem[req.addr] = req.wdata;
                end
                @(negedge CLK);
                peri_req_ready = 1'b0;
                delay = $urandom % 4;
                repeat (delay) @(negedge CLK);
                peri_resp_valid = 1'b1;
                peri_rdata = peri_mem.exists(req.addr) ? peri_mem[req.addr] : 32'd0;
                @(negedge CLK);
                peri_resp_valid = 1'b0;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Checks and case runner
    //////////////////////////////////////////////////////////////////////

    task automatic compare_word(input string name, input logic [31:0] expected,
                                input logic [31:0] actual);
        checks++;
        assert (expected == actual)
        else
        begin
            errors++;
            $display("mismatch %s expected %h actual %h", name, expected, actual);
        end
    endtask

    // Called on a falling edge, returns on a falling edge
    task automatic run_case(input int idx);
        logic [31:0] op;
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [3:0]  strb;
        logic [31:0] expected;
        logic [31:0] rdata;
        logic        is_console;
        logic        is_peri;
        logic        pulse_now;
        logic        pulse_after;
        logic [31:0] pulse_data;
        logic        pulse_expected;
        int          accepts_before;
        string       name;
        op         = case_mem[idx*fields+1];
        addr       = case_mem[idx*fields+2];
        wdata      = case_mem[idx*fields+3];
        strb       = case_mem[idx*fields+4][3:0];
        expected   = case_mem[idx*fields+5];
        name       = $sformatf("case %0d", idx);
        is_console = (addr == mem_pkg::exit_fifo_addr);
        is_peri    = !is_console && (addr >= mem_pkg::peri_base_addr);
        accepts_before = peri_accepts;

        run_en         = case_mem[idx*fields][0];
        proc_req.op    = mem_pkg::mem_op_e'(op[1:0]);
        proc_req.addr  = addr;
        proc_req.wdata = wdata;
        proc_req.strb  = strb;

        if (is_peri && !run_en)
        begin
            // Nothing may start, so the access is withdrawn after a while
            repeat (hold_cycles)
            begin
                @(posedge CLK);
                compare_word({name, " peri_req_valid"}, 32'd0, 32'(peri_req_valid));
                compare_word({name, " proc_ready"}, 32'd0, 32'(proc_ready));
            end
        end
        else
        begin
            do
            begin
                @(posedge CLK);
                // Outside the peripheral region ready tracks the cache
                if (!is_peri)
                begin
                    compare_word({name, " proc_ready"}, 32'(cache_ready),
                                 32'(proc_ready));
                end
            end
            while (!proc_ready);
            rdata = proc_rdata;
            if (!is_console && !is_peri)
            begin
                compare_word({name, " cache op"}, op, 32'(cache_req.op));
                compare_word({name, " cache addr"}, addr, cache_req.addr);
                compare_word({name, " cache wdata"}, wdata, cache_req.wdata);
                compare_word({name, " cache strb"}, 32'(strb), 32'(cache_req.strb));
            end
            else
            begin
                compare_word({name, " cache op"}, 32'd0, 32'(cache_req.op));
            end
            if (op == 32'd1)
            begin
                compare_word({name, " rdata"}, expected, rdata);
            end
        end

        // Two idle cycles show the console pulse and its end
        @(negedge CLK);
        proc_req.op = mem_pkg::op_idle;
        @(posedge CLK);
        pulse_now  = console_valid;
        pulse_data = console_data;
        @(posedge CLK);
        pulse_after = console_valid;
        pulse_expected = is_console && (op == 32'd2) && run_en;
        compare_word({name, " console_valid"}, 32'(pulse_expected), 32'(pulse_now));
        compare_word({name, " console_valid end"}, 32'd0, 32'(pulse_after));
        if (pulse_expected)
        begin
            compare_word({name, " console_data"}, wdata, pulse_data);
        end
        compare_word({name, " peri accepts"}, 32'(is_peri && run_en),
                     peri_accepts - accepts_before);
        if (is_peri && run_en)
        begin
            compare_word({name, " peri write"}, 32'(op == 32'd2), 32'(peri_seen.write));
            compare_word({name, " peri addr"}, addr, peri_seen.addr);
            compare_word({name, " peri wdata"}, wdata, peri_seen.wdata);
            compare_word({name, " peri strb"}, 32'(strb), 32'(peri_seen.strb));
        end
        @(negedge CLK);
    endtask

    //////////////////////////////////////////////////////////////////////
    // Main sequence and watchdog
    //////////////////////////////////////////////////////////////////////

    initial
    begin : main
        int i;
        void'($urandom(93));
        rst      = 1'b1;
        run_en   = 1'b0;
        proc_req = '0;
        for (i = 0; i < max_cases*fields; i++)
        begin
            case_mem[i] = '1;
        end
        $readmemh("tests/router_cases.txt", case_mem);
        while (n_cases < max_cases && case_mem[n_cases*fields] != '1)
        begin
            n_cases++;
        end
        loaded = 1'b1;
        if (n_cases == 0)
        begin
            errors++;
            $display("no cases could be read from tests/router_cases.txt");
        end

        repeat (reset_cycles) @(negedge CLK);
        rst = 1'b0;
        compare_word("reset peri_req_valid", 32'd0, 32'(peri_req_valid));
        compare_word("reset console_valid", 32'd0, 32'(console_valid));

        for (i = 0; i < n_cases; i++)
        begin
            run_case(i);
        end

        $display("%0d cases, %0d checks, %0d errors", n_cases, checks, errors);
        if (errors == 0)
        begin
            $display("TB PASSED");
        end
        else
        begin
            $display("TB FAILED");
        end
        $finish;
    end

    initial
    begin : watchdog
        wait (loaded);
        #((n_cases * cycles_per_case + reset_cycles) * period);
        $display("timeout, the cases did not finish in %0d cycles",
                 n_cases * cycles_per_case + reset_cycles);
        $display("TB FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: tests/router_cases.txt
// run_en op addr wdata strb expected_rdata, all hex
// op 1 is read, 2 is write, 3 is flush; expected_rdata is checked on reads only
1 1 00001000 00000000 f ffffefff
1 2 00002004 cafe0001 f 00000000
1 1 00002004 00000000 f ffffdffb
1 2 00010150 00000041 1 00000000
1 2 00010150 00000042 1 00000000
1 2 10000010 12345678 f 00000000
1 1 10000010 00000000 f 12345678
1 1 10000020 00000000 f 00000000
1 2 20000000 a5a5a5a5 f 00000000
1 1 20000000 00000000 f a5a5a5a5
0 2 00010150 000000ff 1 00000000
0 2 10000030 deadbeef f 00000000
0 1 10000030 00000000 f 00000000
1 1 10000030 00000000 f 00000000
1 1 fffffffc 00000000 f 00000000
1 2 10000010 87654321 f 00000000
1 1 10000010 00000000 f 87654321
1 3 00003000 00000000 f 00000000
1 1 0001014c 00000000 f fffefeb3
1 1 0fffffff 00000000 f f0000000
1 2 00010150 00000043 1 00000000
1 1 00010150 00000000 f fffefeaf

// File: sim.f
source/mem_pkg.sv
source/access_decode.sv
source/peri_sequencer.sv
source/data_port_router.sv
tests/data_port_router_sva.sv
tests/tb_data_port_router.sv

// File: run.sh
#!/bin/sh
# Compile with Verilator, run, and look for the pass message in the output
verilator --binary --timing --assert --top-module tb_data_port_router -f sim.f -o tb_sim \
    && ./obj_dir/tb_sim | tee /dev/stderr | grep -q "^TB PASSED$" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
